// File: src/umi_pkg.sv
package umi_pkg;

    localparam int umi_aw        = 64;
    localparam int umi_idw       = 64;
    localparam int umi_odw       = 128;
    localparam int umi_out_bytes = 16;

    // Opcodes that may merge
    localparam logic [4:0] umi_opc_read      = 5'd1;
    localparam logic [4:0] umi_opc_read_resp = 5'd2;
    localparam logic [4:0] umi_opc_write     = 5'd3;
    localparam logic [4:0] umi_opc_write_resp = 5'd4;
    localparam logic [4:0] umi_opc_posted    = 5'd5;
    localparam logic [4:0] umi_opc_rdma      = 5'd7;

    // Command word, top bit first
    typedef struct packed {
        logic [4:0] hostid;
        logic [1:0] user;
        logic       ex;
        logic       eof;
        logic       eom;
        logic [1:0] prot;
        logic [3:0] qos;
        logic [7:0] len;
        logic [2:0] size;
        logic [4:0] opcode;
    } umi_cmd_t;

    typedef union packed {
        logic [31:0] raw;
        umi_cmd_t    f;
    } umi_cmd_u;

    typedef struct packed {
        umi_cmd_u           cmd;
        logic [umi_aw-1:0]  dstaddr;
        logic [umi_aw-1:0]  srcaddr;
        logic [umi_idw-1:0] data;
    } umi_in_pkt_t;

    typedef struct packed {
        umi_cmd_u           cmd;
        logic [umi_aw-1:0]  dstaddr;
        logic [umi_aw-1:0]  srcaddr;
        logic [umi_odw-1:0] data;
    } umi_out_pkt_t;

    // Held packet plus what ingress worked out about it
    typedef struct packed {
        umi_in_pkt_t pkt;
        logic [4:0]  bytes;
        logic        mergeable;
    } umi_stage_t;

endpackage

// File: src/umi_ingress.sv
`timescale 1ns/1ps

module umi_ingress (
    input  logic                 clk,
    input  logic                 nreset,
    input  logic                 in_valid,
    input  umi_pkg::umi_in_pkt_t in_pkt,
    output logic                 in_ready,
    input  logic                 stage_ready,
    output logic                 stage_valid,
    output umi_pkg::umi_stage_t  stage
);

    logic [1:0]                 reset_done;
    logic                       in_commit;
    logic                       stage_commit;
    logic [4:0]                 in_bytes;
    logic                       opc_ok;
    logic                       field_match;
    logic                       in_mergeable;

    umi_pkg::umi_in_pkt_t       held_pkt;
    logic [4:0]                 held_bytes;
    logic                       held_mergeable;
    logic [umi_pkg::umi_aw-1:0] next_dstaddr;
    logic [umi_pkg::umi_aw-1:0] next_srcaddr;

    // Hold off the source for two cycles after reset
    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            reset_done <= 2'b00;
        end else begin
            reset_done <= {reset_done[0], 1'b1};
        end
    end

    assign in_ready     = reset_done[1] & (~stage_valid | stage_ready);
    assign in_commit    = in_valid & in_ready;
    assign stage_commit = stage_valid & stage_ready;

    // 2^size * (len + 1)
    assign in_bytes = 5'((16'd1 << in_pkt.cmd.f.size) * ({8'd0, in_pkt.cmd.f.len} + 16'd1));

    always_comb begin
        case (in_pkt.cmd.f.opcode)
            umi_pkg::umi_opc_read,
            umi_pkg::umi_opc_read_resp,
            umi_pkg::umi_opc_write,
            umi_pkg::umi_opc_write_resp,
            umi_pkg::umi_opc_posted,
            umi_pkg::umi_opc_rdma:       opc_ok = 1'b1;
            default:                     opc_ok = 1'b0;
        endcase
    end

    // Compare against the last accepted packet
    assign field_match = (in_pkt.cmd.f.opcode == held_pkt.cmd.f.opcode) &
                         (in_pkt.cmd.f.size   == held_pkt.cmd.f.size) &
                         (in_pkt.cmd.f.qos    == held_pkt.cmd.f.qos) &
                         (in_pkt.cmd.f.prot   == held_pkt.cmd.f.prot) &
                         (in_pkt.cmd.f.eof    == held_pkt.cmd.f.eof) &
                         (in_pkt.cmd.f.user   == held_pkt.cmd.f.user) &
                         (in_pkt.cmd.f.hostid == held_pkt.cmd.f.hostid) &
                         (in_pkt.dstaddr == next_dstaddr) &
                         (in_pkt.srcaddr == next_srcaddr);

    // Only a packet arriving while the previous one is still held can continue it
    assign in_mergeable = opc_ok & field_match & ~in_pkt.cmd.f.ex & stage_valid;

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            stage_valid    <= 1'b0;
            held_bytes     <= 5'd0;
            held_mergeable <= 1'b0;
        end else if (in_commit) begin
            stage_valid    <= 1'b1;
            held_bytes     <= in_bytes;
            held_mergeable <= in_mergeable;
        end else if (stage_commit) begin
            stage_valid    <= 1'b0;
            held_mergeable <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_commit) begin
            held_pkt     <= in_pkt;
            next_dstaddr <= in_pkt.dstaddr + {59'd0, in_bytes};
            next_srcaddr <= in_pkt.srcaddr + {59'd0, in_bytes};
        end
    end

    assign stage = '{pkt: held_pkt, bytes: held_bytes, mergeable: held_mergeable};

    // First two edges after reset release take no packet
    a_no_commit_in_reset_delay: assert property (
        @(posedge clk) disable iff (!nreset)
        (!$past(nreset) || !$past(nreset, 2)) |-> !in_commit
    );

endmodule

// File: src/umi_merge_buffer.sv
`timescale 1ns/1ps

module umi_merge_buffer (
    input  logic                       clk,
    input  logic                       nreset,
    input  logic                       stage_valid,
    input  umi_pkg::umi_stage_t        stage,
    output logic                       stage_ready,
    input  logic                       out_eom,
    input  logic                       out_ready,
    output logic                       out_valid,
    output logic [umi_pkg::umi_odw-1:0] out_data,
    output logic [4:0]                 out_bytes,
    output logic                       first_load,
    output logic                       out_commit
);

    logic [4:0]                  byte_count;
    logic [5:0]                  byte_sum;
    logic                        overflow;
    logic                        stage_commit;
    logic                        buf_empty;
    logic [umi_pkg::umi_odw-1:0] byte_mask;
    logic [umi_pkg::umi_odw-1:0] stage_masked;
    logic [umi_pkg::umi_odw-1:0] stage_shifted;
    logic [umi_pkg::umi_odw-1:0] data_q;

    assign buf_empty = (byte_count == 5'd0);
    assign byte_sum  = {1'b0, byte_count} + {1'b0, stage.bytes};
    assign overflow  = (byte_sum > 6'(umi_pkg::umi_out_bytes));

    // Flush on group end, eom, or when the staged packet would not fit
    assign out_valid = ((~stage.mergeable | out_eom) & ~buf_empty) | overflow;
    assign out_commit = out_valid & out_ready;

    // A staged packet enters an empty or draining buffer, or continues an open group
    assign stage_ready = out_commit |
                         (stage.mergeable & ~out_eom & ~overflow) |
                         buf_empty;

    assign stage_commit = stage_valid & stage_ready;
    assign first_load   = stage_commit & (buf_empty | out_commit);

    // Keep only the valid bytes of the incoming data
    assign byte_mask     = ~({umi_pkg::umi_odw{1'b1}} << {stage.bytes, 3'b000});
    assign stage_masked  = {{(umi_pkg::umi_odw - umi_pkg::umi_idw){1'b0}}, stage.pkt.data} &
                           byte_mask;
    assign stage_shifted = stage_masked << {byte_count, 3'b000};

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            byte_count <= 5'd0;
        end else if (first_load) begin
            byte_count <= stage.bytes;
        end else if (stage_commit) begin
            byte_count <= byte_sum[4:0];
        end else if (out_commit) begin
            byte_count <= 5'd0;
        end
    end

    // Restart from the staged packet, else append above the bytes already held
    always_ff @(posedge clk) begin
        if (first_load) begin
            data_q <= stage_masked;
        end else if (stage_commit) begin
            data_q <= data_q | stage_shifted;
        end
    end

    assign out_data  = data_q;
    assign out_bytes = byte_count;

    a_count_in_range: assert property (
        @(posedge clk) disable iff (!nreset)
        byte_count <= 5'(umi_pkg::umi_out_bytes)
    );

    a_out_hold: assert property (
        @(posedge clk) disable iff (!nreset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
    );

endmodule

// File: src/umi_egress.sv
`timescale 1ns/1ps

module umi_egress (
    input  logic                  clk,
    input  logic                  nreset,
    input  umi_pkg::umi_stage_t   stage,
    input  logic                  stage_commit,
    input  logic                  first_load,
    input  logic [4:0]            out_bytes,
    output umi_pkg::umi_out_pkt_t out_pkt,
    output logic                  out_eom
);

    umi_pkg::umi_cmd_t          hdr_cmd;
    logic [umi_pkg::umi_aw-1:0] hdr_dstaddr;
    logic [umi_pkg::umi_aw-1:0] hdr_srcaddr;
    logic [7:0]                 merged_len;
    umi_pkg::umi_cmd_u          out_cmd;

    // Newest packet sets the command fields
    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            hdr_cmd <= '0;
        end else if (stage_commit) begin
            hdr_cmd <= stage.pkt.cmd.f;
        end
    end

    // Addresses come from the first packet of a group
    always_ff @(posedge clk) begin
        if (first_load) begin
            hdr_dstaddr <= stage.pkt.dstaddr;
            hdr_srcaddr <= stage.pkt.srcaddr;
        end
    end

    // Length in units of size, minus one
    assign merged_len = ({3'b000, out_bytes} >> hdr_cmd.size) - 8'd1;

    always_comb begin
        out_cmd.f     = hdr_cmd;
        out_cmd.f.len = merged_len;
    end

    assign out_eom = hdr_cmd.eom;

    // Data lanes are filled in by the merge buffer
    assign out_pkt = '{cmd:     out_cmd.raw,
                       dstaddr: hdr_dstaddr,
                       srcaddr: hdr_srcaddr,
                       data:    '0};

endmodule

// File: src/umi_packet_merge.sv
`timescale 1ns/1ps

module umi_packet_merge (
    input  logic                  clk,
    input  logic                  nreset,
    input  logic                  in_valid,
    input  umi_pkg::umi_in_pkt_t  in_pkt,
    output logic                  in_ready,
    output logic                  out_valid,
    output umi_pkg::umi_out_pkt_t out_pkt,
    input  logic                  out_ready
);

    umi_pkg::umi_stage_t         stage;
    logic                        stage_valid;
    logic                        stage_ready;
    logic                        stage_commit;
    logic                        first_load;
    logic                        out_eom;
    logic [4:0]                  out_bytes;
    logic [umi_pkg::umi_odw-1:0] out_data;
    umi_pkg::umi_out_pkt_t       hdr_pkt;

    assign stage_commit = stage_valid & stage_ready;

    umi_ingress i_umi_ingress (
        .clk         (clk),
        .nreset      (nreset),
        .in_valid    (in_valid),
        .in_pkt      (in_pkt),
        .in_ready    (in_ready),
        .stage_ready (stage_ready),
        .stage_valid (stage_valid),
        .stage       (stage)
    );

    umi_merge_buffer i_umi_merge_buffer (
        .clk         (clk),
        .nreset      (nreset),
        .stage_valid (stage_valid),
        .stage       (stage),
        .stage_ready (stage_ready),
        .out_eom     (out_eom),
        .out_ready   (out_ready),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_bytes   (out_bytes),
        .first_load  (first_load),
        .out_commit  ()
    );

    umi_egress i_umi_egress (
        .clk          (clk),
        .nreset       (nreset),
        .stage        (stage),
        .stage_commit (stage_commit),
        .first_load   (first_load),
        .out_bytes    (out_bytes),
        .out_pkt      (hdr_pkt),
        .out_eom      (out_eom)
    );

    // Header from egress, data from the buffer
    assign out_pkt = '{cmd:     hdr_pkt.cmd,
                       dstaddr: hdr_pkt.dstaddr,
                       srcaddr: hdr_pkt.srcaddr,
                       data:    out_data};

endmodule

// File: dv/umi_merge_checker.sv
`timescale 1ns/1ps

module umi_merge_checker #(
    parameter int num_entries = 20
) (
    input  logic                  clk,
    input  logic                  nreset,
    input  logic                  in_ready,
    input  logic                  out_valid,
    input  logic                  out_ready,
    input  umi_pkg::umi_out_pkt_t out_pkt,
    input  umi_pkg::umi_in_pkt_t  tbl_pkt [num_entries],
    input  int                    tbl_idle [num_entries],
    output int                    error_count,
    output int                    out_count,
    output int                    exp_count,
    output logic                  done
);

    umi_pkg::umi_out_pkt_t exp_q [$];
    umi_pkg::umi_out_pkt_t exp_pkt;
    umi_pkg::umi_out_pkt_t held_pkt;
    logic                  stalled = 1'b0;
    int                    errors = 0;
    int                    received = 0;
    int                    expected_total = 0;
    int                    reset_cycles = 0;

    assign error_count = errors;
    assign out_count   = received;
    assign exp_count   = expected_total;
    assign done        = (expected_total > 0) && (received == expected_total);

    // Size in bytes is (len + 1) units of 2^size bytes
    function automatic int nbytes(input umi_pkg::umi_in_pkt_t p);
        return (int'(p.cmd.f.len) + 1) << p.cmd.f.size;
    endfunction

    function automatic logic [127:0] valid_data(input umi_pkg::umi_in_pkt_t p);
        logic [127:0] r;
        r = '0;
        for (int k = 0; k < 8; k++) begin
            if (k < nbytes(p)) begin
                r[8*k +: 8] = p.data[8*k +: 8];
            end
        end
        return r;
    endfunction

    function automatic logic continues(input umi_pkg::umi_in_pkt_t p,
                                       input umi_pkg::umi_in_pkt_t n);
        logic opc_ok;
        opc_ok = n.cmd.f.opcode inside {umi_pkg::umi_opc_read, umi_pkg::umi_opc_read_resp,
                                        umi_pkg::umi_opc_write, umi_pkg::umi_opc_write_resp,
                                        umi_pkg::umi_opc_posted, umi_pkg::umi_opc_rdma};
        return opc_ok && !n.cmd.f.ex &&
               n.cmd.f.opcode == p.cmd.f.opcode && n.cmd.f.size == p.cmd.f.size &&
               n.cmd.f.qos == p.cmd.f.qos && n.cmd.f.prot == p.cmd.f.prot &&
               n.cmd.f.eof == p.cmd.f.eof && n.cmd.f.user == p.cmd.f.user &&
               n.cmd.f.hostid == p.cmd.f.hostid &&
               n.dstaddr == p.dstaddr + 64'(nbytes(p)) &&
               n.srcaddr == p.srcaddr + 64'(nbytes(p));
    endfunction

    // Reference model: split the table into output groups
    task automatic build_expected();
        int i;
        int j;
        int total;
        logic [127:0] acc;
        umi_pkg::umi_cmd_u c;
        umi_pkg::umi_out_pkt_t e;
        i = 0;
        while (i < num_entries) begin
            acc = valid_data(tbl_pkt[i]);
            total = nbytes(tbl_pkt[i]);
            j = i + 1;
            while (j < num_entries && tbl_idle[j] == 0 &&
                   continues(tbl_pkt[j-1], tbl_pkt[j]) && !tbl_pkt[j-1].cmd.f.eom &&
                   total + nbytes(tbl_pkt[j]) <= umi_pkg::umi_out_bytes) begin
                acc = acc | (valid_data(tbl_pkt[j]) << (8 * total));
                total += nbytes(tbl_pkt[j]);
                j++;
            end
            c = tbl_pkt[j-1].cmd;
            c.f.len = 8'((total >> c.f.size) - 1);
            e.cmd = c;
            e.dstaddr = tbl_pkt[i].dstaddr;
            e.srcaddr = tbl_pkt[i].srcaddr;
            e.data = acc;
            exp_q.push_back(e);
            i = j;
        end
        expected_total = exp_q.size();
    endtask

    task automatic mismatch(input string name, input logic [127:0] exp, input logic [127:0] got);
        $display("Mismatch %s in output %0d: expected %h, got %h", name, received, exp, got);
        errors++;
    endtask

    initial begin
        #1;
        build_expected();
    end

    // Sampled mid-cycle, where every input and output is settled
    always @(negedge clk) begin
        if (!nreset || reset_cycles < 2) begin
            if (in_ready !== 1'b0) mismatch("in_ready", 128'h0, 128'(in_ready));
            if (out_valid !== 1'b0) mismatch("out_valid", 128'h0, 128'(out_valid));
        end
        reset_cycles = !nreset ? 0 : (reset_cycles < 2 ? reset_cycles + 1 : reset_cycles);
        if (stalled) begin
            if (!out_valid) begin
                $display("out_valid dropped before output %0d was accepted", received);
                errors++;
            end else begin
                if (out_pkt.cmd.raw !== held_pkt.cmd.raw)
                    mismatch("stalled out_pkt.cmd", 128'(held_pkt.cmd.raw),
                             128'(out_pkt.cmd.raw));
                if (out_pkt.dstaddr !== held_pkt.dstaddr)
                    mismatch("stalled out_pkt.dstaddr", 128'(held_pkt.dstaddr),
                             128'(out_pkt.dstaddr));
                if (out_pkt.srcaddr !== held_pkt.srcaddr)
                    mismatch("stalled out_pkt.srcaddr", 128'(held_pkt.srcaddr),
                             128'(out_pkt.srcaddr));
                if (out_pkt.data !== held_pkt.data)
                    mismatch("stalled out_pkt.data", held_pkt.data, out_pkt.data);
            end
        end
        if (nreset && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("Output arrived with no merged group left to match it");
                errors++;
            end else begin
                exp_pkt = exp_q.pop_front();
                if (out_pkt.cmd.raw !== exp_pkt.cmd.raw)
                    mismatch("out_pkt.cmd", 128'(exp_pkt.cmd.raw), 128'(out_pkt.cmd.raw));
                if (out_pkt.dstaddr !== exp_pkt.dstaddr)
                    mismatch("out_pkt.dstaddr", 128'(exp_pkt.dstaddr), 128'(out_pkt.dstaddr));
                if (out_pkt.srcaddr !== exp_pkt.srcaddr)
                    mismatch("out_pkt.srcaddr", 128'(exp_pkt.srcaddr), 128'(out_pkt.srcaddr));
                if (out_pkt.data !== exp_pkt.data)
                    mismatch("out_pkt.data", exp_pkt.data, out_pkt.data);
            end
            received++;
        end
        stalled  = nreset && out_valid && !out_ready;
        held_pkt = out_pkt;
    end

endmodule

// File: dv/tb_umi_packet_merge.sv
`timescale 1ns/1ps

module tb_umi_packet_merge;

    localparam int         num_entries     = 20;
    localparam int         watchdog_cycles = num_entries * 40 + 200;
    localparam logic [4:0] opc_wr          = umi_pkg::umi_opc_write;

    logic                  clk;
    logic                  nreset;
    logic                  in_valid;
    umi_pkg::umi_in_pkt_t  in_pkt;
    logic                  in_ready;
    logic                  out_valid;
    umi_pkg::umi_out_pkt_t out_pkt;
    logic                  out_ready;

    umi_pkg::umi_in_pkt_t  stim_pkt [num_entries];
    int                    stim_idle [num_entries];
    integer                seed = 2;
    int                    error_count;
    int                    out_count;
    int                    exp_count;
    logic                  done;
    logic                  accepted;

    umi_packet_merge i_umi_packet_merge (
        .clk       (clk),
        .nreset    (nreset),
        .in_valid  (in_valid),
        .in_pkt    (in_pkt),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_pkt   (out_pkt),
        .out_ready (out_ready)
    );

    umi_merge_checker #(.num_entries(num_entries)) i_umi_merge_checker (
        .clk         (clk),
        .nreset      (nreset),
        .in_ready    (in_ready),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_pkt     (out_pkt),
        .tbl_pkt     (stim_pkt),
        .tbl_idle    (stim_idle),
        .error_count (error_count),
        .out_count   (out_count),
        .exp_count   (exp_count),
        .done        (done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Fixed hostid 3, user 1, prot 0, eof 0
    function automatic umi_pkg::umi_cmd_u make_cmd(input logic [4:0] opcode, input logic [2:0] size,
                                                   input logic [7:0] len, input logic [3:0] qos,
                                                   input logic eom, input logic ex);
        umi_pkg::umi_cmd_u c;
        c.raw      = '0;
        c.f.hostid = 5'd3;
        c.f.user   = 2'd1;
        c.f.opcode = opcode;
        c.f.size   = size;
        c.f.len    = len;
        c.f.qos    = qos;
        c.f.eom    = eom;
        c.f.ex     = ex;
        return c;
    endfunction

    task automatic set_entry(input int idx, input int idle, input umi_pkg::umi_cmd_u cmd,
                             input logic [63:0] dst, input logic [63:0] src);
        stim_idle[idx]        = idle;
        stim_pkt[idx].cmd     = cmd;
        stim_pkt[idx].dstaddr = dst;
        stim_pkt[idx].srcaddr = src;
        stim_pkt[idx].data    = 64'h0f1e2d3c4b5a6978 + 64'(idx) * 64'h0101010101010101;
    endtask

    // Watchdog
    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: %0d of %0d merged outputs were still missing",
                 exp_count - out_count, exp_count);
        $display("Test failures found");
        $finish;
    end

    // Sink with random stalls
    initial begin
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            #2 out_ready = ($random(seed) & 3) != 0;
        end
    end

    initial begin
        nreset   = 1'b0;
        in_valid = 1'b0;
        in_pkt   = '0;
        // 8-byte writes, then an overflow into a second group
        set_entry(0, 0, make_cmd(opc_wr, 3'd3, 8'd0, 4'd0, 1'b0, 1'b0), 64'h1000, 64'h8000);
        set_entry(1, 0, make_cmd(opc_wr, 3'd3, 8'd0, 4'd0, 1'b0, 1'b0), 64'h1008, 64'h8008);
        set_entry(2, 0, make_cmd(opc_wr, 3'd3, 8'd0, 4'd0, 1'b0, 1'b0), 64'h1010, 64'h8010);
        set_entry(3, 0, make_cmd(opc_wr, 3'd3, 8'd0, 4'd0, 1'b0, 1'b0), 64'h1018, 64'h8018);
        // Mixed 4 and 2 byte writes
        set_entry(4, 4, make_cmd(opc_wr, 3'd1, 8'd1, 4'd0, 1'b0, 1'b0), 64'h2000, 64'h9000);
        set_entry(5, 0, make_cmd(opc_wr, 3'd1, 8'd0, 4'd0, 1'b0, 1'b0), 64'h2004, 64'h9004);
        set_entry(6, 0, make_cmd(opc_wr, 3'd1, 8'd1, 4'd0, 1'b0, 1'b0), 64'h2006, 64'h9006);
        set_entry(7, 0, make_cmd(opc_wr, 3'd1, 8'd1, 4'd0, 1'b0, 1'b0), 64'h200a, 64'h900a);
        set_entry(8, 0, make_cmd(opc_wr, 3'd1, 8'd1, 4'd0, 1'b0, 1'b0), 64'h200e, 64'h900e);
        set_entry(9, 0, make_cmd(opc_wr, 3'd1, 8'd0, 4'd0, 1'b0, 1'b0), 64'h2012, 64'h9012);
        // qos change, source gap, eom, ex, idle gap
        set_entry(10, 0, make_cmd(opc_wr, 3'd1, 8'd0, 4'd1, 1'b0, 1'b0), 64'h2014, 64'h9014);
        set_entry(11, 0, make_cmd(opc_wr, 3'd1, 8'd1, 4'd1, 1'b0, 1'b0), 64'h2016, 64'h9100);
        set_entry(12, 0, make_cmd(opc_wr, 3'd1, 8'd1, 4'd1, 1'b1, 1'b0), 64'h201a, 64'h9104);
        set_entry(13, 0, make_cmd(opc_wr, 3'd1, 8'd0, 4'd1, 1'b0, 1'b0), 64'h201e, 64'h9108);
        set_entry(14, 0, make_cmd(opc_wr, 3'd1, 8'd0, 4'd1, 1'b0, 1'b1), 64'h2020, 64'h910a);
        set_entry(15, 0, make_cmd(opc_wr, 3'd1, 8'd0, 4'd1, 1'b0, 1'b0), 64'h2022, 64'h910c);
        set_entry(16, 5, make_cmd(opc_wr, 3'd1, 8'd0, 4'd1, 1'b0, 1'b0), 64'h2024, 64'h910e);
        // Opcode outside the mergeable set passes through alone
        set_entry(17, 0, make_cmd(5'd6, 3'd1, 8'd0, 4'd1, 1'b0, 1'b0), 64'h2026, 64'h9110);
        set_entry(18, 0, make_cmd(5'd6, 3'd1, 8'd0, 4'd1, 1'b0, 1'b0), 64'h2028, 64'h9112);
        set_entry(19, 4, make_cmd(umi_pkg::umi_opc_read, 3'd3, 8'd0, 4'd0, 1'b0, 1'b0),
                  64'h3000, 64'ha000);

        repeat (2) @(posedge clk);
        #2 nreset = 1'b1;
        for (int i = 0; i < num_entries; i++) begin
            repeat (stim_idle[i]) begin
                @(posedge clk);
                #2;
            end
            in_valid = 1'b1;
            in_pkt   = stim_pkt[i];
            do begin
                @(negedge clk);
                accepted = in_ready;
                @(posedge clk);
                #2;
            end while (!accepted);
            in_valid = 1'b0;
        end

        wait (done);
        repeat (4) @(posedge clk);
        $display("Errors: %0d, outputs checked: %0d of %0d", error_count, out_count, exp_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: build.f
src/umi_pkg.sv
src/umi_ingress.sv
src/umi_merge_buffer.sv
src/umi_egress.sv
src/umi_packet_merge.sv
dv/umi_merge_checker.sv
dv/tb_umi_packet_merge.sv

// File: run.sh
#!/bin/sh
# Build with Verilator and run; success only if the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module tb_umi_packet_merge -o sim_umi_packet_merge \
    && ./obj_dir/sim_umi_packet_merge | tee /dev/stderr | grep -q "All tests passed!" \
    || exit 1

exit 0
